// ==== hdl/pmmu_params.svh ====
`ifndef PMMU_PARAMS_SVH
`define PMMU_PARAMS_SVH

// ---------------------------------------------------------------------------
// Memory geometry
// ---------------------------------------------------------------------------

`define PMMU_WORDS      10      // log2 of depth, 2^10 = 1K words
`define PMMU_DATA_WIDTH 32      // Bits per memory word

// ---------------------------------------------------------------------------
// Access size codes, funct3[1:0] of LB/LH/LW and SB/SH/SW
// ---------------------------------------------------------------------------

`define PMMU_SIZE_BYTE  2'd0
`define PMMU_SIZE_HALF  2'd1
`define PMMU_SIZE_WORD  2'd2

`endif

// ==== hdl/mem_types_pkg.sv ====
`include "pmmu_params.svh"

// Width types shared by the memory side of the core
package mem_types_pkg;

    // Data word as held in the array
    typedef logic [`PMMU_DATA_WIDTH-1:0] word_t;

    // Full byte address from the ALU or PC
    typedef logic [31:0] byte_addr_t;

    // Word index into the array
    // Byte address with the two lane bits dropped
    typedef logic [`PMMU_WORDS-1:0] word_addr_t;

    // One enable per byte lane
    typedef logic [`PMMU_DATA_WIDTH/8-1:0] byte_en_t;

endpackage

// ==== hdl/lsu_ops_pkg.sv ====
// Load/store access description, as produced by the lane decoder
package lsu_ops_pkg;

    import mem_types_pkg::*;

    // Byte, halfword or word
    typedef logic [1:0] mem_size_t;

    // ---------------------------------------------------------------------------
    // Decoded access, shared by the load and store paths
    // ---------------------------------------------------------------------------
    typedef struct packed {
        mem_size_t  size;           // Normalized size code
        logic       is_unsigned;    // funct3[2], LBU/LHU
        logic [1:0] lane;           // Byte offset in word
        byte_en_t   byte_en;        // Lanes touched, zero if misaligned
        logic       misaligned;     // Half on odd lane or word off lane 0
    } mem_access_t;

endpackage

// ==== hdl/lane_decode.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "pmmu_params.svh"

module lane_decode
    import mem_types_pkg::*;
    import lsu_ops_pkg::*;
(
    input  logic [2:0]  funct3_i,   // ir[14:12] of the load/store
    input  logic [1:0]  lane_i,     // Byte address bits [1:0]
    output mem_access_t access_o
);

    mem_size_t size;
    logic      misaligned;
    byte_en_t  byte_en;

    // Size classification
    always_comb begin
        case (funct3_i[1:0])
            `PMMU_SIZE_BYTE: size = `PMMU_SIZE_BYTE;
            `PMMU_SIZE_HALF: size = `PMMU_SIZE_HALF;
            // 2'b11 has no RV32 meaning, so it is handled as a word
            default:         size = `PMMU_SIZE_WORD;
        endcase
    end

    // ---------------------------------------------------------------------------
    // Alignment check, the only place it is judged
    // ---------------------------------------------------------------------------
    always_comb begin
        case (size)
            `PMMU_SIZE_BYTE: misaligned = 1'b0;        // Any lane is fine
            `PMMU_SIZE_HALF: misaligned = lane_i[0];   // Must sit on lane 0 or 2
            default:         misaligned = |lane_i;     // Word only on lane 0
        endcase
    end

    // Lane enables
    always_comb begin
        case (size)
            `PMMU_SIZE_BYTE: byte_en = 4'b0001 << lane_i;
            `PMMU_SIZE_HALF: byte_en = 4'b0011 << lane_i;   // lane and lane+1
            default:         byte_en = '1;
        endcase
        if (misaligned) begin
            byte_en = '0;       // Nothing lands on a bad access
        end
    end

    assign access_o = '{
        size:        size,
        is_unsigned: funct3_i[2],
        lane:        lane_i,
        byte_en:     byte_en,
        misaligned:  misaligned
    };

endmodule

`default_nettype wire

// ==== hdl/load_align.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "pmmu_params.svh"

module load_align
    import mem_types_pkg::*;
    import lsu_ops_pkg::*;
(
    input  mem_access_t access_i,
    input  word_t       mem_word_i,     // Word straight from the array
    output word_t       load_data_o     // Extended load value
);

    logic [7:0]  byte_val;
    logic [15:0] half_val;
    logic        sign_bit;

    // Byte lane mux
    always_comb begin
        case (access_i.lane)
            2'd0:    byte_val = mem_word_i[7:0];
            2'd1:    byte_val = mem_word_i[15:8];
            2'd2:    byte_val = mem_word_i[23:16];
            default: byte_val = mem_word_i[31:24];
        endcase
    end

    // Halfword lane, upper half when lane bit 1 is set
    assign half_val = access_i.lane[1] ? mem_word_i[31:16] : mem_word_i[15:0];

    // ---------------------------------------------------------------------------
    // Sign or zero extension
    // ---------------------------------------------------------------------------
    always_comb begin
        sign_bit    = 1'b0;         // Zero fill unless signed
        load_data_o = mem_word_i;   // Word passes through
        case (access_i.size)
            `PMMU_SIZE_BYTE: begin
                sign_bit    = ~access_i.is_unsigned & byte_val[7];
                load_data_o = {{(`PMMU_DATA_WIDTH-8){sign_bit}}, byte_val};     // LB/LBU
            end
            `PMMU_SIZE_HALF: begin
                sign_bit    = ~access_i.is_unsigned & half_val[15];
                load_data_o = {{(`PMMU_DATA_WIDTH-16){sign_bit}}, half_val};    // LH/LHU
            end
            default: begin
                load_data_o = mem_word_i;
            end
        endcase
    end

endmodule

`default_nettype wire

// ==== hdl/store_merge.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "pmmu_params.svh"

module store_merge
    import mem_types_pkg::*;
    import lsu_ops_pkg::*;
(
    input  mem_access_t access_i,
    input  word_t       wd_i,           // Register rs2 value
    output word_t       store_word_o    // Lane-placed write word
);

    // ---------------------------------------------------------------------------
    // Replicate the low byte or halfword across the word
    // ---------------------------------------------------------------------------
    // Every lane the access can name holds the store data
    // The byte enables pick which lanes land in the array
    always_comb begin
        case (access_i.size)
            `PMMU_SIZE_BYTE: store_word_o = {4{wd_i[7:0]}};
            `PMMU_SIZE_HALF: store_word_o = {2{wd_i[15:0]}};
            default:         store_word_o = wd_i;
        endcase
    end

endmodule

`default_nettype wire

// ==== hdl/word_memory.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "pmmu_params.svh"

module word_memory
    import mem_types_pkg::*;
(
    input  logic       clk_i,       // Rising edge
    input  word_addr_t addr_i,      // Word index
    input  word_t      data_i,      // Lane-placed write data
    input  byte_en_t   we_i,        // Per-lane write enable, active high
    output word_t      data_o       // Async read of addr_i
);

    localparam int NUM_WORDS = 1 << `PMMU_WORDS;

    // Storage, N words x 32 bits
    word_t mem [0:NUM_WORDS-1];

    // ---------------------------------------------------------------------------
    // Byte-enabled write
    // ---------------------------------------------------------------------------
    always_ff @(posedge clk_i) begin
        for (int i = 0; i < $bits(byte_en_t); i++) begin
            if (we_i[i]) begin
                mem[addr_i][i*8 +: 8] <= data_i[i*8 +: 8];   // Only enabled lanes land
            end
        end
    end

    // Combinational read
    // A write shows up on the next cycle
    assign data_o = mem[addr_i];

endmodule

`default_nettype wire

// ==== hdl/pmmu.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "pmmu_params.svh"

module pmmu
    import mem_types_pkg::*;
    import lsu_ops_pkg::*;
(
    input  logic       clk_i,           // Rising edge
    input  logic       rst_i,           // Sync, active high
    input  logic [2:0] funct3_i,        // Load/store funct3
    input  byte_addr_t byte_addr_i,     // ALU computed address
    input  word_t      wd_i,            // Store data
    input  logic       mwr_i,           // Write strobe, active low
    input  logic       mrd_i,           // Read strobe, active low
    output word_t      rd_o,            // Load result
    output logic       fault_o          // Sticky misalignment flag
);

    mem_access_t access;
    word_t       mem_word;
    word_t       load_data;
    word_t       store_word;
    byte_en_t    mem_we;
    logic        fault_q;

    // ---------------------------------------------------------------------------
    // Decode and the two data paths
    // ---------------------------------------------------------------------------
    lane_decode u_decode (
        .funct3_i (funct3_i),
        .lane_i   (byte_addr_i[1:0]),
        .access_o (access)
    );

    load_align u_load (
        .access_i    (access),
        .mem_word_i  (mem_word),
        .load_data_o (load_data)
    );

    store_merge u_store (
        .access_i     (access),
        .wd_i         (wd_i),
        .store_word_o (store_word)
    );

    // Write only on strobe and aligned
    assign mem_we = (!mwr_i && !access.misaligned) ? access.byte_en : '0;

    word_memory u_mem (
        .clk_i  (clk_i),
        .addr_i (byte_addr_i[`PMMU_WORDS+1:2]),    // Drop lane bits
        .data_i (store_word),
        .we_i   (mem_we),
        .data_o (mem_word)
    );

    // Read data only while strobed and aligned
    assign rd_o = (!mrd_i && !access.misaligned) ? load_data : '0;

    // ---------------------------------------------------------------------------
    // Fault flag, set by any strobed misaligned access
    // ---------------------------------------------------------------------------
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            fault_q <= 1'b0;
        end else if ((!mwr_i || !mrd_i) && access.misaligned) begin
            fault_q <= 1'b1;        // Held until reset
        end
    end

    assign fault_o = fault_q;

endmodule

`default_nettype wire

// ==== tests/tb_pmmu.sv ====
`timescale 1ns/1ns

module tb_pmmu
    import mem_types_pkg::*;
();

    // ---------------------------------------------------------------------------
    // Run length in clock cycles
    // ---------------------------------------------------------------------------
    localparam int RESET_CYCLES = 10;
    localparam int T_WORD       = 128;     // 64 fills plus 64 reads
    localparam int T_BYTE_ST    = 64;
    localparam int T_BYTE_LD    = 144;
    localparam int T_HALF       = 112;
    localparam int T_MISALIGN   = 96;      // Includes two resets
    localparam int T_STROBE     = 48;
    localparam int CYCLE_LIMIT  = 2 * (T_WORD + T_BYTE_ST + T_BYTE_LD + T_HALF
                                       + T_MISALIGN + T_STROBE) + RESET_CYCLES;

    logic       clk_i;
    logic       rst_i;
    logic [2:0] funct3_i;
    byte_addr_t byte_addr_i;
    word_t      wd_i;
    logic       mwr_i;
    logic       mrd_i;
    word_t      rd_o;
    logic       fault_o;

    logic [7:0]  shadow [0:255];   // Byte model of the first 64 words
    logic [31:0] lfsr_q;
    logic        exp_fault;        // Model of the sticky flag
    logic        cur_bad;          // Strobed misaligned access this cycle
    string       cur_test;
    int          error_count;
    int          errors_at_start;
    int          tests_passed;
    int          tests_failed;
    int          cycle_count;

    pmmu dut (
        .clk_i       (clk_i),
        .rst_i       (rst_i),
        .funct3_i    (funct3_i),
        .byte_addr_i (byte_addr_i),
        .wd_i        (wd_i),
        .mwr_i       (mwr_i),
        .mrd_i       (mrd_i),
        .rd_o        (rd_o),
        .fault_o     (fault_o)
    );

    initial begin
        clk_i = 1'b0;
        forever #2 clk_i = ~clk_i;     // 4 ns period
    end

    // Watchdog
    always @(posedge clk_i) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= CYCLE_LIMIT) begin
            $display("Timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("Some tests failed");
            $finish;
        end
    end

    // ---------------------------------------------------------------------------
    // Stimulus source and reference model
    // ---------------------------------------------------------------------------

    // Fibonacci LFSR for x^32 + x^22 + x^2 + x + 1 stepping once per bit
    function automatic logic [31:0] rand_bits(input int nbits);
        logic [31:0] val;
        logic        fb;
        val = '0;
        for (int i = 0; i < nbits; i++) begin
            fb     = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
            lfsr_q = {lfsr_q[30:0], fb};
            val    = {val[30:0], fb};
        end
        return val;
    endfunction

    // Aligned byte address of one of the first 64 words
    function automatic logic [7:0] rand_word_base();
        logic [31:0] r;
        r = rand_bits(6);
        return {r[5:0], 2'b00};
    endfunction

    function automatic int access_bytes(input logic [2:0] f3);
        case (f3[1:0])
            2'd0:    return 1;
            2'd1:    return 2;
            default: return 4;     // Code 3 treated as a word
        endcase
    endfunction

    // Offset must be a multiple of the access size
    function automatic logic is_misaligned(input logic [2:0] f3, input logic [1:0] lane);
        return (int'(lane) % access_bytes(f3)) != 0;
    endfunction

    task automatic model_store(input logic [2:0] f3, input logic [7:0] addr,
                               input logic [31:0] wd);
        int nbytes;
        nbytes = access_bytes(f3);
        if (is_misaligned(f3, addr[1:0])) begin
            return;                        // Write suppressed
        end
        for (int k = 0; k < nbytes; k++) begin
            shadow[int'(addr) + k] = wd[8*k +: 8];   // Low bytes of rs2 go up from addr
        end
    endtask

    function automatic logic [31:0] model_load(input logic [2:0] f3, input logic [7:0] addr);
        logic [31:0] value;
        int          nbytes;
        nbytes = access_bytes(f3);
        value  = '0;
        if (is_misaligned(f3, addr[1:0])) begin
            return '0;
        end
        for (int k = 0; k < nbytes; k++) begin
            value[8*k +: 8] = shadow[int'(addr) + k];
        end
        if (!f3[2] && nbytes < 4 && value[8*nbytes-1]) begin
            for (int b = 8*nbytes; b < 32; b++) begin
                value[b] = 1'b1;           // Sign fill
            end
        end
        return value;
    endfunction

    // ---------------------------------------------------------------------------
    // Bus tasks drive inputs 1 ns after the edge
    // ---------------------------------------------------------------------------
    task automatic drive(input logic [2:0] f3, input logic [31:0] addr, input logic [31:0] wd,
                         input logic wr_n, input logic rd_n);
        @(posedge clk_i);
        if (cur_bad) begin
            exp_fault = 1'b1;              // Flag registered at this edge
        end
        #1;
        funct3_i    = f3;
        byte_addr_i = addr;
        wd_i        = wd;
        mwr_i       = wr_n;
        mrd_i       = rd_n;
        cur_bad     = (!wr_n || !rd_n) && is_misaligned(f3, addr[1:0]);
    endtask

    task automatic check_value(input string what, input logic [31:0] exp_v,
                               input logic [31:0] act_v);
        assert (act_v === exp_v) else begin
            $display("FAIL %s %s: expected %08h, actual %08h", cur_test, what, exp_v, act_v);
            error_count++;
        end
    endtask

    task automatic store_op(input logic [2:0] f3, input logic [7:0] addr,
                            input logic [31:0] wd);
        drive(f3, {24'b0, addr}, wd, 1'b0, 1'b1);
        model_store(f3, addr, wd);
    endtask

    // Strobed load with rd_o and fault_o sampled mid-cycle
    task automatic load_check(input logic [2:0] f3, input logic [7:0] addr);
        logic [31:0] expected;
        drive(f3, {24'b0, addr}, 32'h0, 1'b1, 1'b0);
        expected = model_load(f3, addr);
        #2;
        check_value("rd_o", expected, rd_o);
        check_value("fault_o", {31'b0, exp_fault}, {31'b0, fault_o});
    endtask

    task automatic apply_reset();
        @(posedge clk_i);
        #1;
        rst_i   = 1'b1;
        mwr_i   = 1'b1;
        mrd_i   = 1'b1;
        cur_bad = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk_i);
        #1;
        rst_i     = 1'b0;
        exp_fault = 1'b0;
    endtask

    task automatic start_test(input string name);
        cur_test        = name;
        errors_at_start = error_count;
    endtask

    task automatic finish_test();
        if (error_count == errors_at_start) begin
            tests_passed++;
            $display("test %s: ok", cur_test);
        end else begin
            tests_failed++;
            $display("test %s: %0d errors", cur_test, error_count - errors_at_start);
        end
    endtask

    // ---------------------------------------------------------------------------
    // Test sequence
    // ---------------------------------------------------------------------------
    logic [7:0]  w;
    logic [31:0] d;
    logic [31:0] rnd;

    initial begin
        rst_i       = 1'b1;
        funct3_i    = 3'd0;
        byte_addr_i = '0;
        wd_i        = '0;
        mwr_i       = 1'b1;
        mrd_i       = 1'b1;
        lfsr_q      = 32'hac81_4b60;
        exp_fault   = 1'b0;
        cur_bad     = 1'b0;
        error_count = 0;
        tests_passed = 0;
        tests_failed = 0;
        cycle_count = 0;
        apply_reset();

        start_test("word_round_trip");
        for (int i = 0; i < 64; i++) begin
            store_op(3'd2, 8'(i * 4), rand_bits(32));    // Fill so every read is defined
        end
        for (int i = 0; i < 64; i++) begin
            load_check(3'd2, 8'(i * 4));
        end
        finish_test();

        start_test("byte_stores");
        for (int i = 0; i < 8; i++) begin
            w = rand_word_base();
            for (int lane = 0; lane < 4; lane++) begin
                store_op(3'd0, w + 8'(lane), rand_bits(32));   // Upper bits ignored
                load_check(3'd2, w);
            end
        end
        finish_test();

        start_test("byte_loads");
        for (int i = 0; i < 16; i++) begin
            w = rand_word_base();
            d = rand_bits(32);
            d = (i % 2 == 0) ? (d | 32'h8080_8080) : (d & 32'h7f7f_7f7f);  // Both signs
            store_op(3'd2, w, d);
            for (int lane = 0; lane < 4; lane++) begin
                load_check(3'd0, w + 8'(lane));    // LB
                load_check(3'd4, w + 8'(lane));    // LBU
            end
        end
        finish_test();

        start_test("half_stores_loads");
        for (int i = 0; i < 16; i++) begin
            w = rand_word_base();
            d = rand_bits(32);
            d = (i % 2 == 0) ? (d | 32'h8000_8000) : (d & 32'h7fff_7fff);
            store_op(3'd1, w, d);
            store_op(3'd1, w + 8'd2, {d[15:0], d[31:16]});
            load_check(3'd1, w);
            load_check(3'd5, w);
            load_check(3'd1, w + 8'd2);
            load_check(3'd5, w + 8'd2);
            load_check(3'd2, w);                  // Merged word
        end
        finish_test();

        start_test("misaligned");
        load_check(3'd2, 8'd0);                   // Flag still clear here
        load_check(3'd1, 8'd1);                   // LH on lane 1 with read strobe only
        load_check(3'd2, 8'd0);                   // Flag set by the load alone
        apply_reset();
        check_value("fault_o after load reset", 32'h0, {31'b0, fault_o});
        for (int i = 0; i < 8; i++) begin
            w = rand_word_base();
            store_op(3'd1, w + 8'd1, rand_bits(32));   // SH on lane 1
            load_check(3'd2, w);
            store_op(3'd2, w + 8'd2, rand_bits(32));   // SW on lane 2
            load_check(3'd2, w);
            load_check(3'd1, w + 8'd3);                // rd_o must be zero
            load_check(3'd5, w + 8'd1);
            load_check(3'd0, w + 8'd1);                // Aligned byte keeps the flag
        end
        check_value("fault_o sticky", 32'h1, {31'b0, fault_o});
        apply_reset();
        check_value("fault_o after reset", 32'h0, {31'b0, fault_o});
        finish_test();

        start_test("read_strobe");
        for (int i = 0; i < 16; i++) begin
            rnd = rand_bits(11);
            drive(rnd[2:0], {24'b0, rnd[10:3]}, rand_bits(32), 1'b1, 1'b1);
            #2;
            check_value("rd_o idle", 32'h0, rd_o);
            w = rand_word_base();
            drive(3'd2, {24'b0, w}, rand_bits(32), 1'b1, 1'b1);   // No write strobe
            load_check(3'd2, w);
        end
        finish_test();

        $display("tests ok: %0d, tests failing: %0d, check errors: %0d",
                 tests_passed, tests_failed, error_count);
        if (error_count == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

// ==== pmmu.f ====
+incdir+hdl
hdl/mem_types_pkg.sv
hdl/lsu_ops_pkg.sv
hdl/lane_decode.sv
hdl/load_align.sv
hdl/store_merge.sv
hdl/word_memory.sv
hdl/pmmu.sv
tests/tb_pmmu.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build with Verilator and run; pass only if the pass message shows up
cd "$(dirname "$0")" \
    && verilator --binary --assert --timescale 1ns/1ns --top-module tb_pmmu \
        -f pmmu.f -o tb_pmmu \
    && ./obj_dir/tb_pmmu | tee /dev/stderr | grep "All tests passed" > /dev/null \
    && echo "simulation: pass" \
    || { echo "simulation: fail"; exit 1; }
